//--- Makefile
# Verilator build for the command bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_spi_bridge
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# pass only when the simulation output holds the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
source/bridge_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/cmd_assembler.sv
source/spi_master.sv
source/reply_queue.sv
source/slm_reset_gen.sv
source/spi_bridge_top.sv
verif/spi_bridge_props.sv
verif/tb_spi_bridge.sv

//--- source/bridge_pkg.sv
// bridge shared definitions
// byte and frame types, board timing constants,
// counter widths and the uart state encoding
`default_nettype none

package bridge_pkg;

  ////////////////////////////////////////
  // data types
  ////////////////////////////////////////

  // one uart character, spi address/data byte or reply byte
  typedef logic [7:0] byte_t;

  // whole spi frame as it sits in the shift register
  typedef logic [15:0] spi_word_t;

  // address leaves first, so it lives in the upper half
  typedef struct packed {
    byte_t addr;
    byte_t data;
  } spi_frame_t;

  ////////////////////////////////////////
  // board timing
  ////////////////////////////////////////

  // 62.5 MHz system clock over 20 gives 3.125 Mbaud
  localparam int CLKS_PER_BIT       = 20;
  // sck half period in system clocks
  localparam int SPI_HALF_CYCLES    = 2;
  // address byte plus data byte
  localparam int SPI_FRAME_BITS     = 16;
  // modulator reset tail after the command drops
  localparam int RESET_PULSE_CYCLES = 10;
  localparam int REPLY_DEPTH        = 4;

  // counter widths
  localparam int UART_CNT_W  = $clog2(CLKS_PER_BIT);
  localparam int SPI_HALF_W  = $clog2(SPI_HALF_CYCLES);
  localparam int SPI_BIT_W   = $clog2(SPI_FRAME_BITS);
  localparam int RESET_CNT_W = $clog2(RESET_PULSE_CYCLES + 1);
  localparam int REPLY_PTR_W = $clog2(REPLY_DEPTH);

  // shared by receiver and transmitter
  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

endpackage

`default_nettype wire

//--- source/cmd_assembler.sv
// command assembler
// pairs host bytes into address/data frames, first byte is the address
// holds each frame valid until the spi engine takes it
`timescale 1ns/100ps
`default_nettype none

module cmd_assembler (
  input  wire                    fpga_clk,
  input  wire                    reset_all_cmd_w,
  input  wire                    rx_valid_i,
  input  wire bridge_pkg::byte_t rx_byte_i,
  input  wire                    frame_ready_i,
  output logic                   frame_valid_o,
  output bridge_pkg::spi_frame_t frame_o
);

  import bridge_pkg::*;

  // high while the first byte of a pair is held
  logic  odd_byte;
  byte_t first_byte;
  // frame slot empty, or emptied this cycle
  logic  slot_free;
  logic  pair_done;

  assign slot_free = !frame_valid_o || frame_ready_i;
  assign pair_done = rx_valid_i && odd_byte;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      odd_byte      <= 1'b0;
      frame_valid_o <= 1'b0;
    end else begin
      if (rx_valid_i) begin
        odd_byte <= !odd_byte;
      end
      // pair arriving over a pending frame is lost
      if (pair_done && slot_free) begin
        frame_valid_o <= 1'b1;
      end else if (frame_ready_i) begin
        frame_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge fpga_clk) begin
    if (rx_valid_i && !odd_byte) begin
      first_byte <= rx_byte_i;
    end
    if (pair_done && slot_free) begin
      frame_o.addr <= first_byte;
      frame_o.data <= rx_byte_i;
    end
  end

endmodule

`default_nettype wire

//--- source/reply_queue.sv
// reply FIFO between spi engine and uart transmitter
// REPLY_DEPTH entries, writes dropped when full
// pop in one cycle, launch the transmitter the next
`timescale 1ns/100ps
`default_nettype none

module reply_queue (
  input  wire                    fpga_clk,
  input  wire                    reset_all_cmd_w,
  input  wire                    reply_valid_i,
  input  wire bridge_pkg::byte_t reply_byte_i,
  input  wire                    tx_active_i,
  output logic                   tx_start_o,
  output bridge_pkg::byte_t      tx_byte_o
);

  import bridge_pkg::*;

  byte_t                  mem [REPLY_DEPTH];
  logic [REPLY_PTR_W-1:0] wr_ptr;
  logic [REPLY_PTR_W-1:0] rd_ptr;
  logic [REPLY_PTR_W:0]   count;
  logic                   full;
  logic                   empty;
  logic                   wr_en;
  logic                   pop;

  assign full  = (count == (REPLY_PTR_W + 1)'(REPLY_DEPTH));
  assign empty = (count == '0);
  assign wr_en = reply_valid_i && !full;
  // hold off while a launch is still in flight
  assign pop   = !empty && !tx_active_i && !tx_start_o;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      tx_start_o <= 1'b0;
    end else begin
      // launch step follows the pop step
      tx_start_o <= pop;
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage and read data
  always_ff @(posedge fpga_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= reply_byte_i;
    end
    if (pop) begin
      tx_byte_o <= mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

//--- source/slm_reset_gen.sv
// modulator reset stretcher
// active low reset while the command is high
// and for RESET_PULSE_CYCLES cycles after it drops
`timescale 1ns/100ps
`default_nettype none

module slm_reset_gen (
  input  wire  fpga_clk,
  input  wire  reset_all_cmd_w,
  output logic slm_reset_n_o
);

  import bridge_pkg::*;

  logic [RESET_CNT_W-1:0] rst_cnt;

  // reload while commanded, then count down to zero
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      rst_cnt <= RESET_CNT_W'(RESET_PULSE_CYCLES);
    end else if (rst_cnt != '0) begin
      rst_cnt <= rst_cnt - 1'b1;
    end
  end

  assign slm_reset_n_o = !(reset_all_cmd_w || (rst_cnt != '0));

endmodule

`default_nettype wire

//--- source/spi_bridge_top.sv
// command bridge top level
// uart bytes in, paired into spi writes to the modulator,
// spi reply bytes queued and echoed back over uart
`timescale 1ns/100ps
`default_nettype none

module spi_bridge_top (
  input  wire  fpga_clk,
  input  wire  reset_all_cmd_w,
  input  wire  uart_rx_i,
  input  wire  spi_miso_i,
  output logic uart_tx_o,
  output logic spi_cs_n_o,
  output logic spi_sck_o,
  output logic spi_mosi_o,
  output logic slm_reset_n_o
);

  import bridge_pkg::*;

  ////////////////////////////////////////
  // host to spi
  ////////////////////////////////////////
  logic       rx_valid;
  byte_t      rx_byte;
  logic       frame_valid;
  logic       frame_ready;
  spi_frame_t frame;

  uart_rx u_uart_rx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_serial_i     (uart_rx_i),
    .rx_valid_o      (rx_valid),
    .rx_byte_o       (rx_byte)
  );

  cmd_assembler u_cmd_assembler (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_valid_i      (rx_valid),
    .rx_byte_i       (rx_byte),
    .frame_ready_i   (frame_ready),
    .frame_valid_o   (frame_valid),
    .frame_o         (frame)
  );

  ////////////////////////////////////////
  // spi replies back to host
  ////////////////////////////////////////
  logic  reply_valid;
  byte_t reply_byte;
  logic  tx_start;
  byte_t tx_byte;
  logic  tx_active;

  spi_master u_spi_master (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .frame_valid_i   (frame_valid),
    .frame_i         (frame),
    .spi_miso_i      (spi_miso_i),
    .frame_ready_o   (frame_ready),
    .spi_cs_n_o      (spi_cs_n_o),
    .spi_sck_o       (spi_sck_o),
    .spi_mosi_o      (spi_mosi_o),
    .reply_valid_o   (reply_valid),
    .reply_byte_o    (reply_byte)
  );

  reply_queue u_reply_queue (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .reply_valid_i   (reply_valid),
    .reply_byte_i    (reply_byte),
    .tx_active_i     (tx_active),
    .tx_start_o      (tx_start),
    .tx_byte_o       (tx_byte)
  );

  uart_tx u_uart_tx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .tx_start_i      (tx_start),
    .tx_byte_i       (tx_byte),
    .tx_active_o     (tx_active),
    .tx_serial_o     (uart_tx_o)
  );

  // modulator reset, active low
  slm_reset_gen u_slm_reset_gen (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .slm_reset_n_o   (slm_reset_n_o)
  );

endmodule

`default_nettype wire

//--- source/spi_master.sv
// spi write engine, mode 0
// one 16-bit frame per accepted request, address byte first, msb first
// miso shifts into the same register, low byte comes back as the reply
// cs low spans SPI_FRAME_BITS*2*SPI_HALF_CYCLES plus one half period tail
`timescale 1ns/100ps
`default_nettype none

module spi_master (
  input  wire                        fpga_clk,
  input  wire                        reset_all_cmd_w,
  input  wire                        frame_valid_i,
  input  wire bridge_pkg::spi_frame_t frame_i,
  input  wire                        spi_miso_i,
  output logic                       frame_ready_o,
  output logic                       spi_cs_n_o,
  output logic                       spi_sck_o,
  output logic                       spi_mosi_o,
  output logic                       reply_valid_o,
  output bridge_pkg::byte_t          reply_byte_o
);

  import bridge_pkg::*;

  logic                  busy;
  // half period after the last falling edge
  logic                  tail;
  // cs already high, reply strobe pending
  logic                  finish;
  logic [SPI_HALF_W-1:0] half_cnt;
  logic [SPI_BIT_W-1:0]  bit_cnt;
  spi_word_t             shift_q;
  logic                  accept;
  logic                  half_done;
  logic                  shifting;
  logic                  sck_rise;

  assign frame_ready_o = !busy;
  assign accept        = frame_valid_i && !busy;
  assign half_done     = (half_cnt == SPI_HALF_W'(SPI_HALF_CYCLES - 1));
  assign shifting      = busy && !tail && !finish;
  assign sck_rise      = shifting && half_done && !spi_sck_o;
  // last eight miso samples
  assign reply_byte_o  = shift_q[7:0];

  ////////////////////////////////////////
  // frame sequencing
  ////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      busy          <= 1'b0;
      tail          <= 1'b0;
      finish        <= 1'b0;
      half_cnt      <= '0;
      bit_cnt       <= '0;
      spi_cs_n_o    <= 1'b1;
      spi_sck_o     <= 1'b0;
      spi_mosi_o    <= 1'b0;
      reply_valid_o <= 1'b0;
    end else begin
      reply_valid_o <= 1'b0;
      if (accept) begin
        // cs drops with the first data bit already on mosi
        busy       <= 1'b1;
        half_cnt   <= '0;
        bit_cnt    <= '0;
        spi_cs_n_o <= 1'b0;
        spi_sck_o  <= 1'b0;
        spi_mosi_o <= frame_i.addr[7];
      end else if (finish) begin
        finish        <= 1'b0;
        busy          <= 1'b0;
        reply_valid_o <= 1'b1;
      end else if (busy) begin
        if (!half_done) begin
          half_cnt <= half_cnt + 1'b1;
        end else begin
          half_cnt <= '0;
          if (tail) begin
            tail       <= 1'b0;
            finish     <= 1'b1;
            spi_cs_n_o <= 1'b1;
            spi_mosi_o <= 1'b0;
          end else if (!spi_sck_o) begin
            // rising edge, slave data sampled below
            spi_sck_o <= 1'b1;
          end else begin
            spi_sck_o <= 1'b0;
            if (bit_cnt == SPI_BIT_W'(SPI_FRAME_BITS - 1)) begin
              tail <= 1'b1;
            end else begin
              // next bit goes out at the falling edge
              bit_cnt    <= bit_cnt + 1'b1;
              spi_mosi_o <= shift_q[15];
            end
          end
        end
      end
    end
  end

  // mosi from the top, miso in at the bottom
  always_ff @(posedge fpga_clk) begin
    if (accept) begin
      shift_q <= frame_i;
    end else if (sck_rise) begin
      shift_q <= {shift_q[14:0], spi_miso_i};
    end
  end

endmodule

`default_nettype wire

//--- source/uart_rx.sv
// uart receiver
// 8N1, oversampled at CLKS_PER_BIT clocks per bit
// one rx_valid strobe per character, in the middle of the stop bit
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
  input  wire                 fpga_clk,
  input  wire                 reset_all_cmd_w,
  input  wire                 rx_serial_i,
  output logic                rx_valid_o,
  output bridge_pkg::byte_t   rx_byte_o
);

  import bridge_pkg::*;

  // two flops for metastability, third one for edge detect
  logic                  rx_meta;
  logic                  rx_sync;
  logic                  rx_prev;
  uart_state_e           state;
  logic [UART_CNT_W-1:0] clk_cnt;
  logic [2:0]            bit_idx;
  byte_t                 rx_shift;
  logic                  cnt_done;
  logic                  mid_start;

  // full bit period elapsed
  assign cnt_done  = (clk_cnt == UART_CNT_W'(CLKS_PER_BIT - 1));
  // halfway through the start bit
  assign mid_start = (clk_cnt == UART_CNT_W'((CLKS_PER_BIT - 1) / 2));

  ////////////////////////////////////////
  // line synchronizer
  ////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      // idle line is high
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx_serial_i;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  ////////////////////////////////////////
  // bit FSM
  ////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state      <= UART_IDLE;
      clk_cnt    <= '0;
      bit_idx    <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      case (state)
        UART_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          // falling edge marks a start bit
          if (rx_prev && !rx_sync) begin
            state <= UART_START;
          end
        end
        UART_START: begin
          if (mid_start) begin
            clk_cnt <= '0;
            // glitch, line back high at mid start
            state   <= rx_sync ? UART_IDLE : UART_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_DATA: begin
          if (cnt_done) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= UART_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_STOP: begin
          if (cnt_done) begin
            clk_cnt    <= '0;
            state      <= UART_IDLE;
            // drop characters with a bad stop bit
            rx_valid_o <= rx_sync;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= UART_IDLE;
      endcase
    end
  end

  // lsb arrives first, shift in from the top
  always_ff @(posedge fpga_clk) begin
    if (state == UART_DATA && cnt_done) begin
      rx_shift <= {rx_sync, rx_shift[7:1]};
    end
    // output byte holds until the next good character
    if (state == UART_STOP && cnt_done && rx_sync) begin
      rx_byte_o <= rx_shift;
    end
  end

endmodule

`default_nettype wire

//--- source/uart_tx.sv
// uart transmitter
// 8N1 at CLKS_PER_BIT clocks per bit
// start strobe latches a byte, tx_active covers start to stop bit
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
  input  wire                 fpga_clk,
  input  wire                 reset_all_cmd_w,
  input  wire                 tx_start_i,
  input  wire bridge_pkg::byte_t tx_byte_i,
  output logic                tx_active_o,
  output logic                tx_serial_o
);

  import bridge_pkg::*;

  uart_state_e           state;
  logic [UART_CNT_W-1:0] clk_cnt;
  logic [2:0]            bit_idx;
  byte_t                 tx_data;
  logic                  cnt_done;

  assign cnt_done = (clk_cnt == UART_CNT_W'(CLKS_PER_BIT - 1));

  // byte is captured only when a character starts
  always_ff @(posedge fpga_clk) begin
    if (state == UART_IDLE && tx_start_i) begin
      tx_data <= tx_byte_i;
    end
  end

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state       <= UART_IDLE;
      clk_cnt     <= '0;
      bit_idx     <= '0;
      tx_active_o <= 1'b0;
      tx_serial_o <= 1'b1;
    end else begin
      case (state)
        UART_IDLE: begin
          // line parks high
          tx_serial_o <= 1'b1;
          clk_cnt     <= '0;
          bit_idx     <= '0;
          if (tx_start_i) begin
            tx_active_o <= 1'b1;
            tx_serial_o <= 1'b0;
            state       <= UART_START;
          end
        end
        UART_START: begin
          if (cnt_done) begin
            clk_cnt     <= '0;
            tx_serial_o <= tx_data[0];
            state       <= UART_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_DATA: begin
          if (cnt_done) begin
            clk_cnt <= '0;
            if (bit_idx == 3'd7) begin
              // stop bit
              tx_serial_o <= 1'b1;
              state       <= UART_STOP;
            end else begin
              bit_idx     <= bit_idx + 1'b1;
              tx_serial_o <= tx_data[bit_idx + 3'd1];
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_STOP: begin
          if (cnt_done) begin
            clk_cnt     <= '0;
            tx_active_o <= 1'b0;
            state       <= UART_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= UART_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verif/spi_bridge_props.sv
// spi framing and modulator reset properties
// bound into the spi engine and the reset generator
`timescale 1ns/100ps
`default_nettype none

module spi_bridge_props (
  input wire fpga_clk,
  input wire reset_all_cmd_w,
  input wire cs_n_i,
  input wire sck_i,
  input wire slm_reset_n_i
);

  import bridge_pkg::*;

  // cycles with chip select low in the current frame
  int unsigned cs_low_cnt;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w || cs_n_i) begin
      cs_low_cnt <= 0;
    end else begin
      cs_low_cnt <= cs_low_cnt + 1;
    end
  end

  ////////////////////////////////////////
  // spi framing
  ////////////////////////////////////////
  sck_idle_low: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    cs_n_i |-> !sck_i)
    else $error("sck high while chip select is high");

  // sixteen bit periods plus the half period tail
  cs_low_span: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    $rose(cs_n_i) |-> (cs_low_cnt == SPI_FRAME_BITS * 2 * SPI_HALF_CYCLES + SPI_HALF_CYCLES))
    else $error("chip select low for %0d cycles", cs_low_cnt);

  ////////////////////////////////////////
  // modulator reset
  ////////////////////////////////////////
  reset_release: assert property (@(posedge fpga_clk)
    $fell(reset_all_cmd_w) |-> ##RESET_PULSE_CYCLES slm_reset_n_i)
    else $error("modulator reset still low after the pulse length");

endmodule

// unused side of each instance tied to idle levels
bind spi_master spi_bridge_props u_spi_props (
  .fpga_clk        (fpga_clk),
  .reset_all_cmd_w (reset_all_cmd_w),
  .cs_n_i          (spi_cs_n_o),
  .sck_i           (spi_sck_o),
  .slm_reset_n_i   (1'b1)
);

bind slm_reset_gen spi_bridge_props u_reset_props (
  .fpga_clk        (fpga_clk),
  .reset_all_cmd_w (reset_all_cmd_w),
  .cs_n_i          (1'b1),
  .sck_i           (1'b0),
  .slm_reset_n_i   (slm_reset_n_o)
);

`default_nettype wire

//--- verif/tb_spi_bridge.sv
// command bridge testbench
// uart host serializer, uart echo deserializer and spi slave model
// table of host byte pairs and slave replies applied in a loop
`timescale 1ns/100ps
`default_nettype none

module tb_spi_bridge;

  import bridge_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_ROWS     = 6;
  localparam int CHAR_CYCLES  = 10 * CLKS_PER_BIT;
  // cs low span plus setup slack
  localparam int FRAME_CYCLES = SPI_FRAME_BITS * 2 * SPI_HALF_CYCLES + 2 * SPI_HALF_CYCLES;
  // two host characters, one frame, one echoed character
  localparam int PAIR_CYCLES  = 3 * CHAR_CYCLES + FRAME_CYCLES;
  localparam int TEST_CYCLES  = (NUM_ROWS + 4) * PAIR_CYCLES
                                + 3 * (RESET_CYCLES + 4 * RESET_PULSE_CYCLES);
  localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

  typedef struct packed {
    byte_t     host_a;
    byte_t     host_b;
    byte_t     reply;
    logic      rand_reply;
    spi_word_t exp_word;
    byte_t     exp_echo;
  } row_t;

  logic fpga_clk;
  logic reset_all_cmd_w;
  logic uart_rx_i;
  logic spi_miso_i;
  logic uart_tx_o;
  logic spi_cs_n_o;
  logic spi_sck_o;
  logic spi_mosi_o;
  logic slm_reset_n_o;

  row_t        rows [NUM_ROWS];
  logic [31:0] rng_state;
  int          errors;
  int          checks_done;
  int          tests_done;
  byte_t       echo_q [$];

  // spi slave model state
  byte_t       slave_reply;
  logic        cs_q;
  logic        sck_q;
  spi_word_t   slave_out;
  spi_word_t   mosi_word;
  spi_word_t   last_word;
  int          rise_cnt;
  int          last_rises;
  int          frames_seen;
  int          cs_falls;

  spi_bridge_top dut0 (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .spi_miso_i      (spi_miso_i),
    .uart_tx_o       (uart_tx_o),
    .spi_cs_n_o      (spi_cs_n_o),
    .spi_sck_o       (spi_sck_o),
    .spi_mosi_o      (spi_mosi_o),
    .slm_reset_n_o   (slm_reset_n_o)
  );

  always #(CLK_PERIOD / 2) fpga_clk = ~fpga_clk;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic compare_values(input string name, input logic [31:0] got,
                                input logic [31:0] want);
    checks_done++;
    if (got !== want) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s got 0x%0h, expected 0x%0h", $time, name, got, want);
    end
  endtask

  task automatic add_row(input int idx, input byte_t a, input byte_t b, input byte_t reply,
                         input logic rnd, input spi_word_t word, input byte_t echo);
    rows[idx] = {a, b, reply, rnd, word, echo};
    // random replies come from the lcg, echo follows the reply
    if (rnd) begin
      rng_state = lcg_next(rng_state);
      rows[idx].reply    = rng_state[31:24];
      rows[idx].exp_echo = rng_state[31:24];
    end
  endtask

  task automatic load_table();
    add_row(0, 8'h01, 8'h80, 8'hA5, 1'b0, 16'h0180, 8'hA5);
    add_row(1, 8'hFF, 8'h00, 8'h3C, 1'b0, 16'hFF00, 8'h3C);
    add_row(2, 8'h5A, 8'hC3, 8'h00, 1'b1, 16'h5AC3, 8'h00);
    add_row(3, 8'h00, 8'hFF, 8'h00, 1'b0, 16'h00FF, 8'h00);
    add_row(4, 8'h7E, 8'h81, 8'h00, 1'b1, 16'h7E81, 8'h00);
    add_row(5, 8'hAA, 8'h55, 8'hFF, 1'b0, 16'hAA55, 8'hFF);
  endtask

  task automatic finish_test(input string name);
    tests_done++;
    $display("test %0d (%s) finished, %0d errors so far", tests_done, name, errors);
  endtask

  // host side, start bit, lsb first, stop bit
  task automatic send_byte(input byte_t value);
    logic [9:0] bits;
    bits = {1'b1, value, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge fpga_clk);
      uart_rx_i <= bits[i];
      repeat (CLKS_PER_BIT - 1) @(posedge fpga_clk);
    end
  endtask

  // reset command plus modulator reset length
  task automatic apply_reset();
    int low_cycles;
    @(posedge fpga_clk);
    reset_all_cmd_w <= 1'b1;
    repeat (RESET_CYCLES) @(posedge fpga_clk);
    compare_values("spi_cs_n_o", 32'(spi_cs_n_o), 32'd1);
    compare_values("uart_tx_o", 32'(uart_tx_o), 32'd1);
    compare_values("slm_reset_n_o", 32'(slm_reset_n_o), 32'd0);
    reset_all_cmd_w <= 1'b0;
    low_cycles = 0;
    @(posedge fpga_clk);
    while (!slm_reset_n_o && low_cycles < 4 * RESET_PULSE_CYCLES) begin
      low_cycles++;
      @(posedge fpga_clk);
    end
    compare_values("slm_reset_n_o low cycles", 32'(low_cycles), 32'(RESET_PULSE_CYCLES));
  endtask

  task automatic wait_frames(input int target);
    int waited;
    waited = 0;
    while (frames_seen < target && waited < 4 * FRAME_CYCLES + CHAR_CYCLES) begin
      @(posedge fpga_clk);
      waited++;
    end
    if (frames_seen < target) begin
      errors++;
      $display("ERROR at %0t ns: no spi frame finished within %0d cycles", $time, waited);
    end
  endtask

  task automatic check_frame(input spi_word_t want);
    compare_values("spi frame word", 32'(last_word), 32'(want));
    compare_values("spi sck rising edges", 32'(last_rises), 32'(SPI_FRAME_BITS));
  endtask

  task automatic wait_echoes(input int count);
    int waited;
    waited = 0;
    while (echo_q.size() < count && waited < (count + 2) * 2 * CHAR_CYCLES) begin
      @(posedge fpga_clk);
      waited++;
    end
    if (echo_q.size() < count) begin
      errors++;
      $display("ERROR at %0t ns: only %0d of %0d echoed characters arrived",
               $time, echo_q.size(), count);
    end
  endtask

  task automatic check_echo(input byte_t want);
    byte_t got;
    if (echo_q.size() == 0) begin
      errors++;
      $display("ERROR at %0t ns: expected echo 0x%0h but nothing was received", $time, want);
    end else begin
      got = echo_q.pop_front();
      compare_values("uart_tx_o echo", 32'(got), 32'(want));
    end
  endtask

  ////////////////////////////////////////
  // spi slave model
  ////////////////////////////////////////
  // capture on rising sck, next reply bit on falling sck
  always @(posedge fpga_clk) begin
    cs_q  <= spi_cs_n_o;
    sck_q <= spi_sck_o;
    if (cs_q && !spi_cs_n_o) begin
      cs_falls   <= cs_falls + 1;
      // address half returns zeros, data half the reply
      slave_out  <= {8'h00, slave_reply};
      spi_miso_i <= 1'b0;
      mosi_word  <= '0;
      rise_cnt   <= 0;
    end else if (!spi_cs_n_o) begin
      if (!sck_q && spi_sck_o) begin
        mosi_word <= {mosi_word[14:0], spi_mosi_o};
        rise_cnt  <= rise_cnt + 1;
      end
      if (sck_q && !spi_sck_o) begin
        slave_out  <= {slave_out[14:0], 1'b0};
        spi_miso_i <= slave_out[14];
      end
    end
    if (!cs_q && spi_cs_n_o) begin
      frames_seen <= frames_seen + 1;
      last_word   <= mosi_word;
      last_rises  <= rise_cnt;
    end
  end

  ////////////////////////////////////////
  // echo deserializer
  ////////////////////////////////////////
  initial begin : echo_capture
    byte_t value;
    logic  line_q;
    line_q = 1'b1;
    value  = '0;
    forever begin
      @(posedge fpga_clk);
      if (line_q && !uart_tx_o && !reset_all_cmd_w) begin
        // edge seen one cycle late, go to mid start bit
        repeat (CLKS_PER_BIT / 2 - 1) @(posedge fpga_clk);
        if (uart_tx_o) begin
          errors++;
          $display("ERROR at %0t ns: start bit on uart_tx_o ended early", $time);
        end
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(posedge fpga_clk);
          value[i] = uart_tx_o;
        end
        repeat (CLKS_PER_BIT) @(posedge fpga_clk);
        if (!uart_tx_o) begin
          errors++;
          $display("ERROR at %0t ns: missing stop bit on uart_tx_o", $time);
        end else begin
          echo_q.push_back(value);
        end
      end
      line_q = uart_tx_o;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge fpga_clk);
    $display("timeout: run still going after %0d clock cycles", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial begin : main_sequence
    int frames_before;
    int falls_before;
    fpga_clk        = 1'b0;
    reset_all_cmd_w = 1'b1;
    uart_rx_i       = 1'b1;
    spi_miso_i      = 1'b0;
    slave_reply     = '0;
    cs_q            = 1'b1;
    sck_q           = 1'b0;
    frames_seen     = 0;
    cs_falls        = 0;
    errors          = 0;
    checks_done     = 0;
    tests_done      = 0;
    rng_state       = 32'h5c7032a3;
    load_table();

    apply_reset();
    finish_test("reset pulse");

    // one frame per row, address byte first
    for (int r = 0; r < NUM_ROWS; r++) begin
      slave_reply   = rows[r].reply;
      frames_before = frames_seen;
      send_byte(rows[r].host_a);
      send_byte(rows[r].host_b);
      wait_frames(frames_before + 1);
      check_frame(rows[r].exp_word);
    end
    finish_test("frame table");

    // replies come back in table order
    wait_echoes(NUM_ROWS);
    for (int r = 0; r < NUM_ROWS; r++) begin
      check_echo(rows[r].exp_echo);
    end
    finish_test("reply echo");

    // lone byte must not start a frame
    slave_reply   = 8'h96;
    falls_before  = cs_falls;
    frames_before = frames_seen;
    send_byte(8'h3D);
    repeat (FRAME_CYCLES + CLKS_PER_BIT) @(posedge fpga_clk);
    compare_values("spi_cs_n_o falls after one byte", 32'(cs_falls), 32'(falls_before));
    send_byte(8'hE2);
    wait_frames(frames_before + 1);
    check_frame(16'h3DE2);
    wait_echoes(1);
    check_echo(8'h96);
    finish_test("split pair");

    // reset between the bytes drops the first one
    repeat (CLKS_PER_BIT) @(posedge fpga_clk);
    slave_reply = 8'h5F;
    send_byte(8'h11);
    apply_reset();
    frames_before = frames_seen;
    send_byte(8'h42);
    send_byte(8'h24);
    wait_frames(frames_before + 1);
    check_frame(16'h4224);
    wait_echoes(1);
    check_echo(8'h5F);
    finish_test("reset mid pair");

    $display("summary: %0d tests, %0d checks, %0d errors", tests_done, checks_done, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
